// ==== Makefile ====
# Verilator build and run of the execute stage testbench

TOP = tb_exu
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
verilog/exu_pkg.sv
verilog/exu_stage_reg.sv
verilog/exu_alu.sv
verilog/exu_muldiv.sv
verilog/exu_writeback.sv
verilog/exu_top.sv
tests/exu_checker.sv
tests/tb_exu.sv

// ==== tests/exu_checker.sv ====
module exu_checker import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            in_valid,
    input  logic            in_ready,
    input  exu_op_e         in_op,
    input  logic [xlen-1:0] in_pc,
    input  logic [xlen-1:0] in_src_a,
    input  logic [xlen-1:0] in_src_b,
    input  logic            out_valid,
    input  logic            out_ready,
    input  logic [xlen-1:0] out_pc,
    input  logic [xlen-1:0] out_result,
    input  int              test_num,
    input  logic            test_done,
    output int              n_checks,
    output int              n_errors,
    output int              pending
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [xlen-1:0] min64 = {1'b1, {(xlen-1){1'b0}}};

    logic [xlen-1:0] exp_pc[$];     // one entry per accepted op, in order
    logic [xlen-1:0] exp_res[$];
    logic [xlen-1:0] e_pc;
    logic [xlen-1:0] e_res;
    logic [xlen-1:0] held_pc;
    logic [xlen-1:0] held_res;
    logic            exp_rdy;
    logic            was_stalled = 1'b0;
    int              t_checks = 0;
    int              t_errors = 0;

    initial begin
        n_checks = 0;
        n_errors = 0;
        pending  = 0;
    end

    function automatic string test_name(input int n);
        case (n)
            1: return "alu64";
            2: return "alu_word";
            3: return "muldiv";
            4: return "backpressure";
            5: return "flush";
            default: return "none";
        endcase
    endfunction

    function automatic logic [xlen-1:0] sext_word(input logic [31:0] w);
        return {{(xlen-32){w[31]}}, w};
    endfunction

    // reference results straight from the ISA rules
    function automatic logic [xlen-1:0] model_result(input exu_op_e op,
                                                     input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b);
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        logic signed [31:0]     wa;
        logic signed [31:0]     wb;
        logic signed [31:0]     wq;
        logic [31:0]            ua;
        logic [31:0]            ub;
        logic                   ovf64;
        logic                   ovf32;
        logic [xlen-1:0]        r;
        sa    = a;
        sb    = b;
        wa    = a[31:0];
        wb    = b[31:0];
        ua    = a[31:0];
        ub    = b[31:0];
        ovf64 = (a == min64) && (b == '1);
        ovf32 = (ua == 32'h8000_0000) && (ub == 32'hffff_ffff);
        r     = '0;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_sll:  r = a << b[5:0];
            op_srl:  r = a >> b[5:0];
            op_sra:  r = sa >>> b[5:0];
            op_slt:  r = (sa < sb) ? 1 : 0;
            op_sltu: r = (a < b) ? 1 : 0;
            op_xor:  r = a ^ b;
            op_or:   r = a | b;
            op_and:  r = a & b;
            op_addw: r = sext_word(ua + ub);
            op_subw: r = sext_word(ua - ub);
            op_sllw: r = sext_word(ua << b[4:0]);
            op_srlw: r = sext_word(ua >> b[4:0]);
            op_sraw: r = sext_word(wa >>> b[4:0]);
            op_mul:  r = a * b;
            op_mulw: r = sext_word(ua * ub);
            op_divu: r = (b == '0) ? '1 : a / b;
            op_remu: r = (b == '0) ? a : a % b;
            op_divuw: r = (ub == 0) ? '1 : sext_word(ua / ub);
            op_remuw: r = (ub == 0) ? sext_word(ua) : sext_word(ua % ub);
            op_div: begin
                if (b == '0) r = '1;
                else if (ovf64) r = a;
                else r = sa / sb;
            end
            op_rem: begin
                if (b == '0) r = a;
                else if (ovf64) r = '0;
                else r = sa % sb;
            end
            op_divw: begin
                if (ub == 0) r = '1;
                else if (ovf32) r = sext_word(ua);
                else begin
                    wq = wa / wb;
                    r  = sext_word(wq);
                end
            end
            op_remw: begin
                if (ub == 0) r = sext_word(ua);
                else if (ovf32) r = '0;
                else begin
                    wq = wa % wb;
                    r  = sext_word(wq);
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic fail_value(input string what, input logic [xlen-1:0] exp,
                              input logic [xlen-1:0] act);
        $display("CHECK FAILED %s %s: expected %h, actual %h",
                 test_name(test_num), what, exp, act);
        n_errors++;
        t_errors++;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            // output must hold while the sink stalls
            if (was_stalled) begin
                if (!out_valid) begin
                    $display("%s: out_valid dropped while the result was stalled",
                             test_name(test_num));
                    n_errors++;
                    t_errors++;
                end else begin
                    if (out_pc !== held_pc) fail_value("stalled pc", held_pc, out_pc);
                    if (out_result !== held_res) fail_value("stalled result", held_res, out_result);
                end
            end
            was_stalled = out_valid && !out_ready && !flush;
            held_pc     = out_pc;
            held_res    = out_result;

            // one op in flight at most, so the queue tells whether the stage is full
            exp_rdy = !flush && (exp_pc.size() == 0 || (out_valid && out_ready));
            if (in_ready !== exp_rdy) fail_value("in_ready", exp_rdy, in_ready);

            if (out_valid && out_ready) begin
                if (exp_pc.size() == 0) begin
                    $display("%s: result for pc %h came out with no op pending",
                             test_name(test_num), out_pc);
                    n_errors++;
                    t_errors++;
                end else begin
                    e_pc  = exp_pc.pop_front();
                    e_res = exp_res.pop_front();
                    n_checks++;
                    t_checks++;
                    if (out_pc !== e_pc) fail_value("pc", e_pc, out_pc);
                    if (out_result !== e_res) fail_value("result", e_res, out_result);
                end
            end

            if (flush) begin      // held op is gone
                exp_pc.delete();
                exp_res.delete();
            end

            if (in_valid && in_ready) begin
                exp_pc.push_back(in_pc);
                exp_res.push_back(model_result(in_op, in_src_a, in_src_b));
            end

            if (test_done) begin
                $display("test %0d %s: %0d results checked, %0d errors",
                         test_num, test_name(test_num), t_checks, t_errors);
                t_checks = 0;
                t_errors = 0;
            end
        end
        pending = exp_pc.size();
    end

endmodule

// ==== tests/tb_exu.sv ====
module tb_exu import exu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int step_bits  = 2;
    localparam int n_alu      = 200;
    localparam int n_word     = 100;
    localparam int n_directed = 12;
    localparam int n_md       = 100;
    localparam int n_mixed    = 200;
    localparam int n_flush    = 150;
    localparam int n_ops      = n_alu + n_word + n_directed + n_md + n_mixed + n_flush;
    localparam longint watchdog_ns = longint'(n_ops) * (xlen / step_bits + 10) * 20;

    logic            clk;
    logic            rst_n;
    logic            flush;
    logic            in_valid;
    exu_op_e         in_op;
    logic [xlen-1:0] in_pc;
    logic [xlen-1:0] in_src_a;
    logic [xlen-1:0] in_src_b;
    logic            out_ready;
    logic            in_ready;
    logic            out_valid;
    logic [xlen-1:0] out_pc;
    logic [xlen-1:0] out_result;

    integer          seed = 32'h9019;
    logic [xlen-1:0] next_pc;
    logic            stall_on;
    logic            flush_on;
    int              test_num;
    logic            test_done;
    int              n_checks;
    int              n_errors;
    int              pending;

    exu_top #(
        .step_bits (step_bits)
    ) i_exu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_pc      (in_pc),
        .in_src_a   (in_src_a),
        .in_src_b   (in_src_b),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_result (out_result)
    );

    exu_checker i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_pc      (in_pc),
        .in_src_a   (in_src_a),
        .in_src_b   (in_src_b),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_pc     (out_pc),
        .out_result (out_result),
        .test_num   (test_num),
        .test_done  (test_done),
        .n_checks   (n_checks),
        .n_errors   (n_errors),
        .pending    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // back-pressure and flush, drawn at the edge and driven 2 ns later
    always @(posedge clk) begin
        int   r;
        logic ready_next;
        logic flush_next;
        r          = $random(seed);
        ready_next = !stall_on || (r[1:0] != 2'b00);
        flush_next = flush_on && (r[7:4] == 4'd0);
        #2;
        out_ready = ready_next;
        flush     = flush_next;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [xlen-1:0] rand_xlen();
        return {$random(seed), $random(seed)};
    endfunction

    // hold the op until the stage takes it
    task automatic send_op(input exu_op_e op, input logic [xlen-1:0] a,
                           input logic [xlen-1:0] b);
        logic taken;
        in_valid = 1'b1;
        in_op    = op;
        in_pc    = next_pc;
        in_src_a = a;
        in_src_b = b;
        taken    = 1'b0;
        while (!taken) begin
            #1;
            taken = in_ready;    // settled, holds until the edge
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
        next_pc  = next_pc + 4;
    endtask

    task automatic run_random(input int first, input int span, input int count);
        exu_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        for (int i = 0; i < count; i++) begin
            op = exu_op_e'(first + rand_below(span));
            a  = rand_xlen();
            b  = rand_xlen();
            if (rand_below(4) == 0) b = b >> rand_below(xlen);   // small divisors too
            send_op(op, a, b);
        end
    endtask

    task automatic end_test();
        while (pending != 0) begin
            @(posedge clk);
            #2;
        end
        test_done = 1'b1;
        @(posedge clk);
        #2;
        test_done = 1'b0;
        test_num  = test_num + 1;
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: run still going after %0d ns", watchdog_ns);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_op     = op_add;
        in_pc     = '0;
        in_src_a  = '0;
        in_src_b  = '0;
        out_ready = 1'b1;
        stall_on  = 1'b0;
        flush_on  = 1'b0;
        test_num  = 1;
        test_done = 1'b0;
        next_pc   = 64'h1000;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        run_random(int'(op_add), 10, n_alu);
        end_test();
        run_random(int'(op_addw), 5, n_word);
        end_test();

        for (int k = int'(op_div); k <= int'(op_remuw); k++) begin   // divide by zero
            send_op(exu_op_e'(k), rand_xlen(), (k >= int'(op_divw)) ? {$random(seed), 32'h0} : '0);
        end
        send_op(op_div, {1'b1, {(xlen-1){1'b0}}}, '1);
        send_op(op_rem, {1'b1, {(xlen-1){1'b0}}}, '1);
        send_op(op_divw, {$random(seed), 32'h8000_0000}, {$random(seed), 32'hffff_ffff});
        send_op(op_remw, {$random(seed), 32'h8000_0000}, {$random(seed), 32'hffff_ffff});
        run_random(int'(op_mul), 10, n_md);
        end_test();

        stall_on = 1'b1;
        run_random(0, 25, n_mixed);
        stall_on = 1'b0;
        end_test();

        flush_on = 1'b1;
        run_random(0, 25, n_flush);
        flush_on = 1'b0;
        end_test();

        $display("closing: %0d results checked, %0d errors", n_checks, n_errors);
        if (n_errors == 0 && n_checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog/exu_alu.sv ====
module exu_alu import exu_pkg::*; (
    input  exu_op_e         ex_op,
    input  logic [xlen-1:0] ex_src_a,
    input  logic [xlen-1:0] ex_src_b,
    output logic [xlen-1:0] alu_result
);

    logic [word_bits-1:0] a_w;
    logic [word_bits-1:0] b_w;
    logic [word_bits-1:0] w_res;
    logic [5:0]           sh6;     // 64-bit shift amount
    logic [4:0]           sh5;     // word shift amount

    assign a_w = ex_src_a[word_bits-1:0];
    assign b_w = ex_src_b[word_bits-1:0];
    assign sh6 = ex_src_b[5:0];
    assign sh5 = ex_src_b[4:0];

    always_comb begin
        alu_result = '0;
        w_res      = '0;
        case (ex_op)
            op_add:  alu_result = ex_src_a + ex_src_b;
            op_sub:  alu_result = ex_src_a - ex_src_b;
            op_sll:  alu_result = ex_src_a << sh6;
            op_srl:  alu_result = ex_src_a >> sh6;
            op_sra:  alu_result = $signed(ex_src_a) >>> sh6;
            op_slt: begin
                alu_result = {{(xlen-1){1'b0}}, $signed(ex_src_a) < $signed(ex_src_b)};
            end
            op_sltu: alu_result = {{(xlen-1){1'b0}}, ex_src_a < ex_src_b};
            op_xor:  alu_result = ex_src_a ^ ex_src_b;
            op_or:   alu_result = ex_src_a | ex_src_b;
            op_and:  alu_result = ex_src_a & ex_src_b;
            op_addw: w_res = a_w + b_w;
            op_subw: w_res = a_w - b_w;
            op_sllw: w_res = a_w << sh5;
            op_srlw: w_res = a_w >> sh5;
            op_sraw: w_res = $signed(a_w) >>> sh5;
            default: ;                          // mul/div handled elsewhere
        endcase

        // raw word result, upper half filled in by the writeback
        if (is_word_op(ex_op)) begin
            alu_result = {{(xlen-word_bits){1'b0}}, w_res};
        end
    end

endmodule

// ==== verilog/exu_muldiv.sv ====
module exu_muldiv import exu_pkg::*; #(
    parameter int step_bits = 1
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            ex_valid,
    input  exu_op_e         ex_op,
    input  logic [xlen-1:0] ex_src_a,
    input  logic [xlen-1:0] ex_src_b,
    input  logic            md_consume,
    output logic [xlen-1:0] md_result,
    output logic            md_done
);

    localparam int steps = xlen / step_bits;
    localparam int cnt_w = $clog2(steps + 1);

    muldiv_state_e    state;
    logic [cnt_w-1:0] cnt;
    logic             start;
    logic             sdiv;
    logic [xlen-1:0]  a_nar;
    logic [xlen-1:0]  b_nar;
    logic             a_neg;
    logic             b_neg;

    // acc is product or partial remainder, opa multiplicand or quotient, opb multiplier or divisor
    logic [xlen-1:0]  acc;
    logic [xlen-1:0]  opa;
    logic [xlen-1:0]  opb;
    logic             is_div_q;
    logic             is_rem_q;
    logic             dz_q;      // divide by zero
    logic             qneg_q;
    logic             rneg_q;

    logic [xlen-1:0]  acc_n;
    logic [xlen-1:0]  opa_n;
    logic [xlen-1:0]  opb_n;
    logic [xlen:0]    rem_sh;
    logic [xlen-1:0]  quo;
    logic [xlen-1:0]  rem;

    assign start = ex_valid && is_muldiv_op(ex_op) && (state == st_idle);
    assign sdiv  = is_signed_div(ex_op);

    always_comb begin
        a_nar = ex_src_a;
        b_nar = ex_src_b;
        if (is_word_op(ex_op)) begin
            a_nar = {{(xlen-word_bits){sdiv && ex_src_a[word_bits-1]}}, ex_src_a[word_bits-1:0]};
            b_nar = {{(xlen-word_bits){sdiv && ex_src_b[word_bits-1]}}, ex_src_b[word_bits-1:0]};
        end
    end

    assign a_neg = sdiv && a_nar[xlen-1];
    assign b_neg = sdiv && b_nar[xlen-1];

    // step_bits iterations per clock
    always_comb begin
        acc_n  = acc;
        opa_n  = opa;
        opb_n  = opb;
        rem_sh = '0;
        for (int i = 0; i < step_bits; i++) begin
            if (is_div_q) begin
                rem_sh = {acc_n, opa_n[xlen-1]};
                opa_n  = {opa_n[xlen-2:0], 1'b0};
                if (rem_sh >= {1'b0, opb_n}) begin    // restoring compare
                    rem_sh   = rem_sh - {1'b0, opb_n};
                    opa_n[0] = 1'b1;
                end
                acc_n = rem_sh[xlen-1:0];
            end else begin
                if (opb_n[0]) begin
                    acc_n = acc_n + opa_n;
                end
                opa_n = {opa_n[xlen-2:0], 1'b0};
                opb_n = {1'b0, opb_n[xlen-1:1]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc      <= '0;
            opa      <= a_neg ? -a_nar : a_nar;   // magnitude, mul ops are never negated
            opb      <= b_neg ? -b_nar : b_nar;
            is_div_q <= !(ex_op inside {op_mul, op_mulw});
            is_rem_q <= is_rem_op(ex_op);
            dz_q     <= (b_nar == '0);
            qneg_q   <= a_neg ^ b_neg;
            rneg_q   <= a_neg;                    // remainder follows the dividend
        end else if (state == st_busy) begin
            acc <= acc_n;
            opa <= opa_n;
            opb <= opb_n;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            cnt     <= '0;
            md_done <= 1'b0;
        end else if (flush) begin
            state   <= st_idle;
            md_done <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_busy;
                        cnt   <= '0;
                    end
                end
                st_busy: begin
                    if (cnt == cnt_w'(steps - 1)) begin
                        state   <= st_done;
                        md_done <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_done: begin
                    if (md_consume) begin
                        state   <= st_idle;
                        md_done <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // -MIN / -1 needs no special case, the magnitude quotient already equals the dividend
    assign quo = dz_q ? '1 : (qneg_q ? -opa : opa);
    assign rem = rneg_q ? -acc : acc;     // for x/0 this gives back x

    always_comb begin
        if (!is_div_q) begin
            md_result = acc;
        end else if (is_rem_q) begin
            md_result = rem;
        end else begin
            md_result = quo;
        end
    end

    a_start_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_busy) && !$past(state == st_busy) |-> $past(state == st_idle && start));

    a_done_flag: assert property (@(posedge clk) disable iff (!rst_n)
        md_done == (state == st_done));

endmodule

// ==== verilog/exu_pkg.sv ====
package exu_pkg;

    parameter int xlen      = 64;
    parameter int word_bits = 32;   // width of the *w forms

    typedef enum logic [4:0] {
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_mul, op_mulw,
        op_div, op_divu, op_rem, op_remu,
        op_divw, op_divuw, op_remw, op_remuw
    } exu_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } muldiv_state_e;

    function automatic logic is_muldiv_op(exu_op_e op);
        return op inside {op_mul, op_mulw, op_div, op_divu, op_rem, op_remu,
                          op_divw, op_divuw, op_remw, op_remuw};
    endfunction

    // 32-bit forms, result gets sign-extended from bit 31
    function automatic logic is_word_op(exu_op_e op);
        return op inside {op_addw, op_subw, op_sllw, op_srlw, op_sraw, op_mulw,
                          op_divw, op_divuw, op_remw, op_remuw};
    endfunction

    function automatic logic is_signed_div(exu_op_e op);
        return op inside {op_div, op_rem, op_divw, op_remw};
    endfunction

    function automatic logic is_rem_op(exu_op_e op);
        return op inside {op_rem, op_remu, op_remw, op_remuw};
    endfunction

endpackage

// ==== verilog/exu_stage_reg.sv ====
module exu_stage_reg import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            advance,
    input  logic            in_valid,
    input  exu_op_e         in_op,
    input  logic [xlen-1:0] in_pc,
    input  logic [xlen-1:0] in_src_a,
    input  logic [xlen-1:0] in_src_b,
    output logic            ex_valid,
    output exu_op_e         ex_op,
    output logic [xlen-1:0] ex_pc,
    output logic [xlen-1:0] ex_src_a,
    output logic [xlen-1:0] ex_src_b
);

    logic load;

    assign load = advance && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;   // held op is dropped
        end else if (load) begin
            ex_valid <= in_valid;
        end
    end

    // payload only moves on a load
    always_ff @(posedge clk) begin
        if (load) begin
            ex_op    <= in_op;
            ex_pc    <= in_pc;
            ex_src_a <= in_src_a;
            ex_src_b <= in_src_b;
        end
    end

    a_hold_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && !advance |=> $stable(ex_op) && $stable(ex_pc)
                                 && $stable(ex_src_a) && $stable(ex_src_b));

endmodule

// ==== verilog/exu_top.sv ====
module exu_top import exu_pkg::*; #(
    parameter int step_bits = 1    // bits retired per cycle by mul/div
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            in_valid,
    input  exu_op_e         in_op,
    input  logic [xlen-1:0] in_pc,
    input  logic [xlen-1:0] in_src_a,
    input  logic [xlen-1:0] in_src_b,
    input  logic            out_ready,
    output logic            in_ready,
    output logic            out_valid,
    output logic [xlen-1:0] out_pc,
    output logic [xlen-1:0] out_result
);

    logic            ex_valid;
    exu_op_e         ex_op;
    logic [xlen-1:0] ex_src_a;
    logic [xlen-1:0] ex_src_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] md_result;
    logic            md_done;
    logic            md_consume;

    exu_stage_reg i_stage_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .advance  (in_ready),     // stage loads whenever upstream sees ready
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_pc    (in_pc),
        .in_src_a (in_src_a),
        .in_src_b (in_src_b),
        .ex_valid (ex_valid),
        .ex_op    (ex_op),
        .ex_pc    (out_pc),       // pc only rides along as a tag
        .ex_src_a (ex_src_a),
        .ex_src_b (ex_src_b)
    );

    exu_alu i_alu (
        .ex_op      (ex_op),
        .ex_src_a   (ex_src_a),
        .ex_src_b   (ex_src_b),
        .alu_result (alu_result)
    );

    exu_muldiv #(
        .step_bits (step_bits)
    ) i_muldiv (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .ex_valid   (ex_valid),
        .ex_op      (ex_op),
        .ex_src_a   (ex_src_a),
        .ex_src_b   (ex_src_b),
        .md_consume (md_consume),
        .md_result  (md_result),
        .md_done    (md_done)
    );

    exu_writeback i_writeback (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_op      (ex_op),
        .alu_result (alu_result),
        .md_result  (md_result),
        .md_done    (md_done),
        .out_ready  (out_ready),
        .flush      (flush),
        .out_valid  (out_valid),
        .out_result (out_result),
        .advance    (in_ready),
        .md_consume (md_consume)
    );

endmodule

// ==== verilog/exu_writeback.sv ====
module exu_writeback import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ex_valid,
    input  exu_op_e         ex_op,
    input  logic [xlen-1:0] alu_result,
    input  logic [xlen-1:0] md_result,
    input  logic            md_done,
    input  logic            out_ready,
    input  logic            flush,
    output logic            out_valid,
    output logic [xlen-1:0] out_result,
    output logic            advance,
    output logic            md_consume
);

    logic            md_op;
    logic            consume;
    logic [xlen-1:0] res;

    assign md_op = is_muldiv_op(ex_op);

    // mul/div results wait for the unit, everything else is ready at once
    assign out_valid = ex_valid && (!md_op || md_done);
    assign consume   = out_valid && out_ready;

    assign advance    = !flush && (!ex_valid || consume);
    assign md_consume = consume && md_op;

    assign res = md_op ? md_result : alu_result;

    always_comb begin
        if (is_word_op(ex_op)) begin
            out_result = {{(xlen-word_bits){res[word_bits-1]}}, res[word_bits-1:0]};
        end else begin
            out_result = res;
        end
    end

    // a freshly loaded mul/div op still has its busy cycles ahead
    a_no_early_md_valid: assert property (@(posedge clk) disable iff (!rst_n)
        advance |=> !(out_valid && md_op));

endmodule
